//--- verilog/pad_map_pkg.sv
`default_nettype none

package pad_map_pkg;

   ////////////////////
   // Pad ring size
   ////////////////////

   localparam int unsigned PAD_COUNT  = 28;
   // One GPIO bit per pad, GPIO n sits on pad n
   localparam int unsigned GPIO_COUNT = PAD_COUNT;
   // Drive strength and pull bits of a single pad
   localparam int unsigned PAD_CFG_W  = 6;

   ////////////////////
   // Pad positions
   ////////////////////

   // SPI master quad data lanes
   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_CSN1  = 5;
   localparam int unsigned PAD_SPIM_SCK   = 6;

   localparam int unsigned PAD_UART_RX    = 7;
   localparam int unsigned PAD_UART_TX    = 8;

   // Camera data is eight pads wide starting at DATA0
   localparam int unsigned PAD_CAM_PCLK   = 9;
   localparam int unsigned PAD_CAM_HSYNC  = 10;
   localparam int unsigned PAD_CAM_DATA0  = 11;
   localparam int unsigned PAD_CAM_VSYNC  = 19;

   // SDIO data is four pads wide starting at DATA0
   localparam int unsigned PAD_SDIO_CLK   = 20;
   localparam int unsigned PAD_SDIO_CMD   = 21;
   localparam int unsigned PAD_SDIO_DATA0 = 22;

   localparam int unsigned PAD_I2C0_SDA   = 26;
   localparam int unsigned PAD_I2C0_SCL   = 27;

   ////////////////////
   // Types
   ////////////////////

   // Per-pad function select
   typedef enum logic [1:0] {
      FUNC_DEFAULT = 2'b00,
      FUNC_GPIO    = 2'b01,
      FUNC_ALT     = 2'b10,
      FUNC_NONE    = 2'b11
   } pad_func_e;

   typedef pad_func_e [PAD_COUNT-1:0] pad_func_arr_t;

   // One bit per pad, also used for the GPIO vectors
   typedef logic [PAD_COUNT-1:0] pad_vec_t;

   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;
   typedef pad_cfg_t [PAD_COUNT-1:0] pad_cfg_arr_t;

endpackage

`default_nettype wire

//--- verilog/periph_pkg.sv
`default_nettype none

package periph_pkg;

   ////////////////////
   // SPI master
   ////////////////////

   // Quad mode data lanes
   localparam int unsigned SPI_LANES     = 4;
   // Only two chip selects reach the pads
   localparam int unsigned SPI_CSN_COUNT = 2;

   typedef logic [SPI_LANES-1:0]     spi_lane_t;
   typedef logic [SPI_CSN_COUNT-1:0] spi_csn_t;

   ////////////////////
   // SDIO and camera
   ////////////////////

   localparam int unsigned SDIO_DATA_W = 4;
   localparam int unsigned CAM_DATA_W  = 8;

   typedef logic [SDIO_DATA_W-1:0] sdio_data_t;
   typedef logic [CAM_DATA_W-1:0]  cam_data_t;

   ////////////////////
   // Timers and I2C
   ////////////////////

   // PWM channels of one timer
   localparam int unsigned TIMER_CH  = 4;
   // Bit 0 is I2C0, bit 1 is I2C1
   localparam int unsigned I2C_COUNT = 2;

   typedef logic [TIMER_CH-1:0]  timer_ch_t;
   typedef logic [I2C_COUNT-1:0] i2c_bus_t;

endpackage

`default_nettype wire

//--- verilog/pad_out_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pad_out_mux (
   input  pad_map_pkg::pad_func_arr_t pad_func_i,
   input  pad_map_pkg::pad_vec_t      gpio_out_i,
   input  pad_map_pkg::pad_vec_t      gpio_dir_i,
   input  logic                       spi_clk_i,
   input  periph_pkg::spi_csn_t       spi_csn_i,
   input  periph_pkg::spi_lane_t      spi_sdo_i,
   input  periph_pkg::spi_lane_t      spi_oen_i,
   input  logic                       sdio_clk_i,
   input  logic                       sdio_cmd_i,
   input  logic                       sdio_cmd_oen_i,
   input  periph_pkg::sdio_data_t     sdio_data_i,
   input  periph_pkg::sdio_data_t     sdio_data_oen_i,
   input  logic                       uart_tx_i,
   input  periph_pkg::i2c_bus_t       i2c_sda_out_i,
   input  periph_pkg::i2c_bus_t       i2c_sda_oe_i,
   input  periph_pkg::i2c_bus_t       i2c_scl_out_i,
   input  periph_pkg::i2c_bus_t       i2c_scl_oe_i,
   input  periph_pkg::timer_ch_t      timer1_i,
   input  periph_pkg::timer_ch_t      timer2_i,
   input  periph_pkg::timer_ch_t      timer3_i,
   output pad_map_pkg::pad_vec_t      pad_out_o,
   output pad_map_pkg::pad_vec_t      pad_oe_o
);

   import pad_map_pkg::*;
   import periph_pkg::*;

   pad_vec_t dflt_out;
   pad_vec_t dflt_oe;
   pad_vec_t alt_out;
   pad_vec_t alt_oe;

   ////////////////////
   // Default sources
   ////////////////////

   always_comb begin
      // Camera pads and UART RX stay input only
      dflt_out = '0;
      dflt_oe  = '0;

      // Peripheral enables are active low
      dflt_out[PAD_SPIM_SDIO0 +: SPI_LANES] = spi_sdo_i;
      dflt_oe[PAD_SPIM_SDIO0 +: SPI_LANES]  = ~spi_oen_i;

      dflt_out[PAD_SPIM_CSN0] = spi_csn_i[0];
      dflt_oe[PAD_SPIM_CSN0]  = 1'b1;
      dflt_out[PAD_SPIM_CSN1] = spi_csn_i[1];
      dflt_oe[PAD_SPIM_CSN1]  = 1'b1;
      dflt_out[PAD_SPIM_SCK]  = spi_clk_i;
      dflt_oe[PAD_SPIM_SCK]   = 1'b1;

      dflt_out[PAD_UART_TX] = uart_tx_i;
      dflt_oe[PAD_UART_TX]  = 1'b1;

      dflt_out[PAD_SDIO_CLK] = sdio_clk_i;
      dflt_oe[PAD_SDIO_CLK]  = 1'b1;
      dflt_out[PAD_SDIO_CMD] = sdio_cmd_i;
      dflt_oe[PAD_SDIO_CMD]  = ~sdio_cmd_oen_i;
      dflt_out[PAD_SDIO_DATA0 +: SDIO_DATA_W] = sdio_data_i;
      dflt_oe[PAD_SDIO_DATA0 +: SDIO_DATA_W]  = ~sdio_data_oen_i;

      // Open drain style, enable comes straight from the controller
      dflt_out[PAD_I2C0_SDA] = i2c_sda_out_i[0];
      dflt_oe[PAD_I2C0_SDA]  = i2c_sda_oe_i[0];
      dflt_out[PAD_I2C0_SCL] = i2c_scl_out_i[0];
      dflt_oe[PAD_I2C0_SCL]  = i2c_scl_oe_i[0];
   end

   ////////////////////
   // Alternate sources
   ////////////////////

   always_comb begin
      // Pads without an alternate function act as unused
      alt_out = '0;
      alt_oe  = '0;

      // I2C1 SDA candidates
      alt_out[PAD_SPIM_SDIO2]     = i2c_sda_out_i[1];
      alt_oe[PAD_SPIM_SDIO2]      = i2c_sda_oe_i[1];
      alt_out[PAD_UART_RX]        = i2c_sda_out_i[1];
      alt_oe[PAD_UART_RX]         = i2c_sda_oe_i[1];
      alt_out[PAD_SDIO_DATA0 + 2] = i2c_sda_out_i[1];
      alt_oe[PAD_SDIO_DATA0 + 2]  = i2c_sda_oe_i[1];

      // I2C1 SCL candidates
      alt_out[PAD_SPIM_SDIO3]     = i2c_scl_out_i[1];
      alt_oe[PAD_SPIM_SDIO3]      = i2c_scl_oe_i[1];
      alt_out[PAD_UART_TX]        = i2c_scl_out_i[1];
      alt_oe[PAD_UART_TX]         = i2c_scl_oe_i[1];
      alt_out[PAD_SDIO_DATA0 + 3] = i2c_scl_out_i[1];
      alt_oe[PAD_SDIO_DATA0 + 3]  = i2c_scl_oe_i[1];

      // Timer channels fill the camera pads, last timer has three pads
      alt_out[PAD_CAM_PCLK +: TIMER_CH]                  = timer1_i;
      alt_out[PAD_CAM_PCLK + TIMER_CH +: TIMER_CH]       = timer2_i;
      alt_out[PAD_CAM_PCLK + 2 * TIMER_CH +: TIMER_CH-1] = timer3_i[TIMER_CH-2:0];
      alt_oe[PAD_CAM_PCLK +: 3 * TIMER_CH - 1]           = '1;
   end

   ////////////////////
   // Per-pad select
   ////////////////////

   for (genvar p = 0; p < PAD_COUNT; p++) begin : g_pad
      logic out_bit;
      logic oe_bit;

      always_comb begin
         case (pad_func_i[p])
            FUNC_DEFAULT: begin
               out_bit = dflt_out[p];
               oe_bit  = dflt_oe[p];
            end
            FUNC_GPIO: begin
               out_bit = gpio_out_i[p];
               oe_bit  = gpio_dir_i[p];
            end
            FUNC_ALT: begin
               out_bit = alt_out[p];
               oe_bit  = alt_oe[p];
            end
            default: begin
               out_bit = 1'b0;   // FUNC_NONE
               oe_bit  = 1'b0;
            end
         endcase
      end

      assign pad_out_o[p] = out_bit;
      assign pad_oe_o[p]  = oe_bit;
   end

endmodule

`default_nettype wire

//--- verilog/pad_in_route.sv
`timescale 1ns/1ps
`default_nettype none

module pad_in_route (
   input  pad_map_pkg::pad_func_arr_t pad_func_i,
   input  pad_map_pkg::pad_vec_t      pad_in_i,
   output periph_pkg::spi_lane_t      spi_sdi_o,
   output logic                       sdio_cmd_o,
   output periph_pkg::sdio_data_t     sdio_data_o,
   output logic                       uart_rx_o,
   output periph_pkg::i2c_bus_t       i2c_sda_in_o,
   output periph_pkg::i2c_bus_t       i2c_scl_in_o,
   output logic                       cam_pclk_o,
   output logic                       cam_hsync_o,
   output logic                       cam_vsync_o,
   output periph_pkg::cam_data_t      cam_data_o
);

   import pad_map_pkg::*;
   import periph_pkg::*;

   pad_vec_t dflt_sel;
   pad_vec_t alt_sel;
   pad_vec_t dflt_in;
   logic     i2c0_sda;
   logic     i2c0_scl;
   logic     i2c1_sda;
   logic     i2c1_scl;

   // Decode of each pad's own select
   for (genvar p = 0; p < PAD_COUNT; p++) begin : g_sel
      assign dflt_sel[p] = (pad_func_i[p] == FUNC_DEFAULT);
      assign alt_sel[p]  = (pad_func_i[p] == FUNC_ALT);
   end

   // Pad values seen in default mode, zero elsewhere
   assign dflt_in = pad_in_i & dflt_sel;

   ////////////////////
   // Idle low inputs
   ////////////////////

   assign spi_sdi_o = {dflt_in[PAD_SPIM_SDIO3], dflt_in[PAD_SPIM_SDIO2],
                       dflt_in[PAD_SPIM_SDIO1], dflt_in[PAD_SPIM_SDIO0]};

   assign sdio_cmd_o  = dflt_in[PAD_SDIO_CMD];
   assign sdio_data_o = dflt_in[PAD_SDIO_DATA0 +: SDIO_DATA_W];

   assign cam_pclk_o  = dflt_in[PAD_CAM_PCLK];
   assign cam_hsync_o = dflt_in[PAD_CAM_HSYNC];
   assign cam_data_o  = dflt_in[PAD_CAM_DATA0 +: CAM_DATA_W];
   assign cam_vsync_o = dflt_in[PAD_CAM_VSYNC];

   ////////////////////
   // Idle high inputs
   ////////////////////

   // Line stays at the bus idle level when its pad is taken
   assign uart_rx_o = dflt_sel[PAD_UART_RX] ? pad_in_i[PAD_UART_RX] : 1'b1;
   assign i2c0_sda  = dflt_sel[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c0_scl  = dflt_sel[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // I2C1 has three candidate pads per line, lowest pad number wins
   always_comb begin
      if (alt_sel[PAD_SPIM_SDIO2]) begin
         i2c1_sda = pad_in_i[PAD_SPIM_SDIO2];
      end else if (alt_sel[PAD_UART_RX]) begin
         i2c1_sda = pad_in_i[PAD_UART_RX];
      end else if (alt_sel[PAD_SDIO_DATA0 + 2]) begin
         i2c1_sda = pad_in_i[PAD_SDIO_DATA0 + 2];
      end else begin
         i2c1_sda = 1'b1;
      end
   end

   // SCL resolved on its own, independent of SDA
   always_comb begin
      if (alt_sel[PAD_SPIM_SDIO3]) begin
         i2c1_scl = pad_in_i[PAD_SPIM_SDIO3];
      end else if (alt_sel[PAD_UART_TX]) begin
         i2c1_scl = pad_in_i[PAD_UART_TX];
      end else if (alt_sel[PAD_SDIO_DATA0 + 3]) begin
         i2c1_scl = pad_in_i[PAD_SDIO_DATA0 + 3];
      end else begin
         i2c1_scl = 1'b1;
      end
   end

   assign i2c_sda_in_o = {i2c1_sda, i2c0_sda};
   assign i2c_scl_in_o = {i2c1_scl, i2c0_scl};

endmodule

`default_nettype wire

//--- verilog/gpio_pad_bank.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_pad_bank (
   input  pad_map_pkg::pad_func_arr_t pad_func_i,
   input  pad_map_pkg::pad_vec_t      pad_in_i,
   input  pad_map_pkg::pad_cfg_arr_t  gpio_cfg_i,
   input  pad_map_pkg::pad_cfg_arr_t  pad_cfg_i,
   output pad_map_pkg::pad_vec_t      gpio_in_o,
   output pad_map_pkg::pad_cfg_arr_t  pad_cfg_o
);

   import pad_map_pkg::*;

   ////////////////////
   // GPIO bits
   ////////////////////

   // GPIO n is tied to pad n, so one loop covers both sides
   for (genvar n = 0; n < GPIO_COUNT; n++) begin : g_gpio
      logic     is_gpio;
      pad_cfg_t cfg_sel;

      assign is_gpio = (pad_func_i[n] == FUNC_GPIO);

      // GPIO block sees zero while another function owns the pad
      assign gpio_in_o[n] = is_gpio & pad_in_i[n];

      // Electrical settings follow whoever owns the pad
      always_comb begin
         if (is_gpio) begin
            cfg_sel = gpio_cfg_i[n];
         end else begin
            cfg_sel = pad_cfg_i[n];
         end
      end

      assign pad_cfg_o[n] = cfg_sel;
   end

endmodule

`default_nettype wire

//--- verilog/pad_ring_top.sv
`timescale 1ns/1ps
`default_nettype none

module pad_ring_top (
   // Function select, one field per pad
   input  pad_map_pkg::pad_func_arr_t pad_func_i,

   // GPIO side
   input  pad_map_pkg::pad_vec_t      gpio_out_i,
   input  pad_map_pkg::pad_vec_t      gpio_dir_i,
   output pad_map_pkg::pad_vec_t      gpio_in_o,
   input  pad_map_pkg::pad_cfg_arr_t  gpio_cfg_i,

   // Pad configuration
   input  pad_map_pkg::pad_cfg_arr_t  pad_cfg_i,
   output pad_map_pkg::pad_cfg_arr_t  pad_cfg_o,

   // SPI master
   input  logic                       spi_clk_i,
   input  periph_pkg::spi_csn_t       spi_csn_i,
   input  periph_pkg::spi_lane_t      spi_sdo_i,
   input  periph_pkg::spi_lane_t      spi_oen_i,
   output periph_pkg::spi_lane_t      spi_sdi_o,

   // SDIO
   input  logic                       sdio_clk_i,
   input  logic                       sdio_cmd_i,
   input  logic                       sdio_cmd_oen_i,
   output logic                       sdio_cmd_o,
   input  periph_pkg::sdio_data_t     sdio_data_i,
   input  periph_pkg::sdio_data_t     sdio_data_oen_i,
   output periph_pkg::sdio_data_t     sdio_data_o,

   // UART
   input  logic                       uart_tx_i,
   output logic                       uart_rx_o,

   // I2C0 and I2C1
   input  periph_pkg::i2c_bus_t       i2c_sda_out_i,
   input  periph_pkg::i2c_bus_t       i2c_sda_oe_i,
   output periph_pkg::i2c_bus_t       i2c_sda_in_o,
   input  periph_pkg::i2c_bus_t       i2c_scl_out_i,
   input  periph_pkg::i2c_bus_t       i2c_scl_oe_i,
   output periph_pkg::i2c_bus_t       i2c_scl_in_o,

   // Camera
   output logic                       cam_pclk_o,
   output logic                       cam_hsync_o,
   output logic                       cam_vsync_o,
   output periph_pkg::cam_data_t      cam_data_o,

   // Timers
   input  periph_pkg::timer_ch_t      timer1_i,
   input  periph_pkg::timer_ch_t      timer2_i,
   input  periph_pkg::timer_ch_t      timer3_i,

   // Pad frame
   input  pad_map_pkg::pad_vec_t      pad_in_i,
   output pad_map_pkg::pad_vec_t      pad_out_o,
   output pad_map_pkg::pad_vec_t      pad_oe_o
);

   // Pad drivers
   pad_out_mux u_pad_out_mux (
      .pad_func_i      (pad_func_i),
      .gpio_out_i      (gpio_out_i),
      .gpio_dir_i      (gpio_dir_i),
      .spi_clk_i       (spi_clk_i),
      .spi_csn_i       (spi_csn_i),
      .spi_sdo_i       (spi_sdo_i),
      .spi_oen_i       (spi_oen_i),
      .sdio_clk_i      (sdio_clk_i),
      .sdio_cmd_i      (sdio_cmd_i),
      .sdio_cmd_oen_i  (sdio_cmd_oen_i),
      .sdio_data_i     (sdio_data_i),
      .sdio_data_oen_i (sdio_data_oen_i),
      .uart_tx_i       (uart_tx_i),
      .i2c_sda_out_i   (i2c_sda_out_i),
      .i2c_sda_oe_i    (i2c_sda_oe_i),
      .i2c_scl_out_i   (i2c_scl_out_i),
      .i2c_scl_oe_i    (i2c_scl_oe_i),
      .timer1_i        (timer1_i),
      .timer2_i        (timer2_i),
      .timer3_i        (timer3_i),
      .pad_out_o       (pad_out_o),
      .pad_oe_o        (pad_oe_o)
   );

   // Pad inputs back to the peripherals
   pad_in_route u_pad_in_route (
      .pad_func_i   (pad_func_i),
      .pad_in_i     (pad_in_i),
      .spi_sdi_o    (spi_sdi_o),
      .sdio_cmd_o   (sdio_cmd_o),
      .sdio_data_o  (sdio_data_o),
      .uart_rx_o    (uart_rx_o),
      .i2c_sda_in_o (i2c_sda_in_o),
      .i2c_scl_in_o (i2c_scl_in_o),
      .cam_pclk_o   (cam_pclk_o),
      .cam_hsync_o  (cam_hsync_o),
      .cam_vsync_o  (cam_vsync_o),
      .cam_data_o   (cam_data_o)
   );

   // GPIO inputs and pad configuration
   gpio_pad_bank u_gpio_pad_bank (
      .pad_func_i (pad_func_i),
      .pad_in_i   (pad_in_i),
      .gpio_cfg_i (gpio_cfg_i),
      .pad_cfg_i  (pad_cfg_i),
      .gpio_in_o  (gpio_in_o),
      .pad_cfg_o  (pad_cfg_o)
   );

endmodule

`default_nettype wire

//--- verification/pad_ring_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pad_ring_tb;

   import pad_map_pkg::*;
   import periph_pkg::*;

   logic clk;
   logic rst_i;

   pad_func_arr_t pad_func_i;
   pad_vec_t      gpio_out_i, gpio_dir_i, gpio_in_o, pad_in_i, pad_out_o, pad_oe_o;
   pad_cfg_arr_t  gpio_cfg_i, pad_cfg_i, pad_cfg_o;
   logic          spi_clk_i, sdio_clk_i, sdio_cmd_i, sdio_cmd_oen_i, uart_tx_i;
   spi_csn_t      spi_csn_i;
   spi_lane_t     spi_sdo_i, spi_oen_i, spi_sdi_o;
   sdio_data_t    sdio_data_i, sdio_data_oen_i, sdio_data_o;
   i2c_bus_t      i2c_sda_out_i, i2c_sda_oe_i, i2c_scl_out_i, i2c_scl_oe_i;
   i2c_bus_t      i2c_sda_in_o, i2c_scl_in_o;
   timer_ch_t     timer1_i, timer2_i, timer3_i;
   logic          sdio_cmd_o, uart_rx_o, cam_pclk_o, cam_hsync_o, cam_vsync_o;
   cam_data_t     cam_data_o;

   int errors;
   int test_errors;
   int tests_run;
   int tests_failed;

   pad_ring_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Global guard in case the clock itself stops
   initial begin
      #200us;
      $display("Simulation ran past its time limit");
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic wait_rise();
      int guard;
      guard = 0;
      do begin
         @(clk);
         guard++;
      end while (clk !== 1'b1 && guard < 4);
      if (clk !== 1'b1) begin
         $display("No rising clock edge seen within the wait limit");
         $display("TEST FAIL");
         $finish;
      end
   endtask

   task automatic check_vec(string name, logic [255:0] exp, logic [255:0] act);
      if (exp !== act) begin
         $display("** Error %s: expected %0h, actual %0h", name, exp, act);
         test_errors++;
      end
   endtask

   task automatic drive_random_periph();
      gpio_out_i      <= $urandom();
      gpio_dir_i      <= $urandom();
      pad_in_i        <= $urandom();
      spi_clk_i       <= $urandom_range(0, 1);
      spi_csn_i       <= $urandom();
      spi_sdo_i       <= $urandom();
      spi_oen_i       <= $urandom();
      sdio_clk_i      <= $urandom_range(0, 1);
      sdio_cmd_i      <= $urandom_range(0, 1);
      sdio_cmd_oen_i  <= $urandom_range(0, 1);
      sdio_data_i     <= $urandom();
      sdio_data_oen_i <= $urandom();
      uart_tx_i       <= $urandom_range(0, 1);
      i2c_sda_out_i   <= $urandom();
      i2c_sda_oe_i    <= $urandom();
      i2c_scl_out_i   <= $urandom();
      i2c_scl_oe_i    <= $urandom();
      timer1_i        <= $urandom();
      timer2_i        <= $urandom();
      timer3_i        <= $urandom();
      for (int p = 0; p < PAD_COUNT; p++) begin
         gpio_cfg_i[p] <= $urandom();
         pad_cfg_i[p]  <= $urandom();
      end
   endtask

   task automatic drive_all_func(pad_func_e f);
      for (int p = 0; p < PAD_COUNT; p++) begin
         pad_func_i[p] <= f;
      end
   endtask

   // Expected output and enable of one pad, from the pad mode rules
   function automatic logic [1:0] model_pad(int p);
      int idx;
      case (pad_func_i[p])
         FUNC_DEFAULT: begin
            if (p < 4) return {spi_sdo_i[p], ~spi_oen_i[p]};
            if (p == 4 || p == 5) return {spi_csn_i[p-4], 1'b1};
            if (p == 6) return {spi_clk_i, 1'b1};
            if (p == 8) return {uart_tx_i, 1'b1};
            if (p == 20) return {sdio_clk_i, 1'b1};
            if (p == 21) return {sdio_cmd_i, ~sdio_cmd_oen_i};
            if (p >= 22 && p <= 25) return {sdio_data_i[p-22], ~sdio_data_oen_i[p-22]};
            if (p == 26) return {i2c_sda_out_i[0], i2c_sda_oe_i[0]};
            if (p == 27) return {i2c_scl_out_i[0], i2c_scl_oe_i[0]};
            return 2'b00;
         end
         FUNC_GPIO: return {gpio_out_i[p], gpio_dir_i[p]};
         FUNC_ALT: begin
            if (p == 2 || p == 7 || p == 24) return {i2c_sda_out_i[1], i2c_sda_oe_i[1]};
            if (p == 3 || p == 8 || p == 25) return {i2c_scl_out_i[1], i2c_scl_oe_i[1]};
            if (p >= 9 && p <= 19) begin
               idx = p - 9;
               if (idx < 4) return {timer1_i[idx], 1'b1};
               if (idx < 8) return {timer2_i[idx-4], 1'b1};
               return {timer3_i[idx-8], 1'b1};
            end
            return 2'b00;
         end
         default: return 2'b00;
      endcase
   endfunction

   function automatic logic dflt_in(int p, logic idle);
      return (pad_func_i[p] == FUNC_DEFAULT) ? pad_in_i[p] : idle;
   endfunction

   // First pad of the list in alternate mode wins
   function automatic logic i2c1_in(int a, int b, int c);
      if (pad_func_i[a] == FUNC_ALT) return pad_in_i[a];
      if (pad_func_i[b] == FUNC_ALT) return pad_in_i[b];
      if (pad_func_i[c] == FUNC_ALT) return pad_in_i[c];
      return 1'b1;
   endfunction

   task automatic check_against_model();
      pad_vec_t   e_out, e_oe, e_gin;
      logic [1:0] r;
      for (int p = 0; p < PAD_COUNT; p++) begin
         r = model_pad(p);
         e_out[p] = r[1];
         e_oe[p]  = r[0];
         e_gin[p] = (pad_func_i[p] == FUNC_GPIO) ? pad_in_i[p] : 1'b0;
         check_vec($sformatf("pad_cfg_o[%0d]", p),
                   (pad_func_i[p] == FUNC_GPIO) ? gpio_cfg_i[p] : pad_cfg_i[p], pad_cfg_o[p]);
      end
      check_vec("pad_out_o", e_out, pad_out_o);
      check_vec("pad_oe_o", e_oe, pad_oe_o);
      check_vec("gpio_in_o", e_gin, gpio_in_o);
      check_vec("spi_sdi_o", {dflt_in(3, 0), dflt_in(2, 0), dflt_in(1, 0), dflt_in(0, 0)},
                spi_sdi_o);
      check_vec("sdio_cmd_o", dflt_in(21, 0), sdio_cmd_o);
      check_vec("sdio_data_o", {dflt_in(25, 0), dflt_in(24, 0), dflt_in(23, 0),
                dflt_in(22, 0)}, sdio_data_o);
      check_vec("uart_rx_o", dflt_in(7, 1), uart_rx_o);
      check_vec("cam_pclk_o", dflt_in(9, 0), cam_pclk_o);
      check_vec("cam_hsync_o", dflt_in(10, 0), cam_hsync_o);
      check_vec("cam_vsync_o", dflt_in(19, 0), cam_vsync_o);
      for (int k = 0; k < CAM_DATA_W; k++) begin
         check_vec($sformatf("cam_data_o[%0d]", k), dflt_in(11 + k, 0), cam_data_o[k]);
      end
      check_vec("i2c_sda_in_o", {i2c1_in(2, 7, 24), dflt_in(26, 1)}, i2c_sda_in_o);
      check_vec("i2c_scl_in_o", {i2c1_in(3, 8, 25), dflt_in(27, 1)}, i2c_scl_in_o);
   endtask

   task automatic finish_test(string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: failed with %0d errors", name, test_errors);
         tests_failed++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic all_gpio_test();
      wait_rise();
      drive_all_func(FUNC_GPIO);
      drive_random_periph();
      wait_rise();
      check_vec("pad_out_o", gpio_out_i, pad_out_o);
      check_vec("pad_oe_o", gpio_dir_i, pad_oe_o);
      check_vec("gpio_in_o", pad_in_i, gpio_in_o);
      check_vec("pad_cfg_o", gpio_cfg_i, pad_cfg_o);
      check_against_model();
      finish_test("all pads gpio");
   endtask

   task automatic all_default_test();
      wait_rise();
      drive_all_func(FUNC_DEFAULT);
      drive_random_periph();
      wait_rise();
      check_vec("gpio_in_o", 0, gpio_in_o);
      check_vec("pad_cfg_o", pad_cfg_i, pad_cfg_o);
      check_vec("pad_oe_o[8]", 1, pad_oe_o[8]);
      check_vec("pad_oe_o[7]", 0, pad_oe_o[7]);
      check_against_model();
      finish_test("all pads default");
   endtask

   task automatic camera_test();
      pad_func_e modes [3] = '{FUNC_DEFAULT, FUNC_GPIO, FUNC_NONE};
      foreach (modes[m]) begin
         wait_rise();
         drive_all_func(FUNC_DEFAULT);
         for (int p = 9; p <= 19; p++) begin
            pad_func_i[p] <= modes[m];
         end
         drive_random_periph();
         wait_rise();
         if (modes[m] == FUNC_DEFAULT) begin
            check_vec("cam_data_o", pad_in_i[18:11], cam_data_o);
         end else begin
            check_vec("cam_data_o", 0, cam_data_o);
         end
         check_against_model();
      end
      finish_test("camera inputs");
   endtask

   task automatic alternate_test();
      pad_vec_t pins;
      // Single pairs first, then the two upper pairs, then every pad
      for (int round = 0; round < 5; round++) begin
         wait_rise();
         drive_all_func(round == 4 ? FUNC_ALT : FUNC_NONE);
         if (round == 0) begin
            pad_func_i[2] <= FUNC_ALT;
            pad_func_i[3] <= FUNC_ALT;
         end
         if (round == 1 || round == 3) begin
            pad_func_i[7] <= FUNC_ALT;
            pad_func_i[8] <= FUNC_ALT;
         end
         if (round == 2 || round == 3) begin
            pad_func_i[24] <= FUNC_ALT;
            pad_func_i[25] <= FUNC_ALT;
         end
         drive_random_periph();
         pins = $urandom();
         // Candidate pads of one I2C1 line disagree so the winner is visible
         pins[7]  = ~pins[2];
         pins[8]  = ~pins[3];
         pins[24] = ~pins[7];
         pins[25] = ~pins[8];
         pad_in_i <= pins;
         wait_rise();
         if (round == 3) begin
            check_vec("i2c_sda_in_o[1]", pad_in_i[7], i2c_sda_in_o[1]);
            check_vec("i2c_scl_in_o[1]", pad_in_i[8], i2c_scl_in_o[1]);
         end
         if (round == 4) begin
            check_vec("pad_out_o[19:9]", {timer3_i[2:0], timer2_i, timer1_i}, pad_out_o[19:9]);
            check_vec("pad_oe_o[19:9]", 11'h7ff, pad_oe_o[19:9]);
            check_vec("i2c_sda_in_o[1]", pad_in_i[2], i2c_sda_in_o[1]);
            check_vec("i2c_scl_in_o[1]", pad_in_i[3], i2c_scl_in_o[1]);
         end
         check_against_model();
      end
      finish_test("alternate mode");
   endtask

   task automatic mixed_test();
      for (int it = 0; it < 20; it++) begin
         wait_rise();
         for (int p = 0; p < PAD_COUNT; p++) begin
            pad_func_i[p] <= pad_func_e'($urandom_range(0, 3));
         end
         drive_random_periph();
         wait_rise();
         check_against_model();
      end
      finish_test("mixed selects");
   endtask

   initial begin
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(44167));
      rst_i = 1'b1;
      drive_all_func(FUNC_NONE);
      drive_random_periph();
      wait_rise();
      wait_rise();
      rst_i <= 1'b0;

      all_gpio_test();
      all_default_test();
      camera_test();
      alternate_test();
      mixed_test();

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
verilog/pad_map_pkg.sv
verilog/periph_pkg.sv
verilog/pad_out_mux.sv
verilog/pad_in_route.sv
verilog/gpio_pad_bank.sv
verilog/pad_ring_top.sv
verification/pad_ring_tb.sv
